//--- files.f
+incdir+include
logic/panel_pkg.sv
logic/panel_sequencer.sv
logic/nixie_scan.sv
logic/keypad_scan.sv
logic/panel_bus_mux.sv
logic/front_panel.sv
tb/front_panel_chk.sv
tb/front_panel_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module front_panel_tb \
	-o front_panel_sim

./obj_dir/front_panel_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- tb/front_panel_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "panel_defs.svh"

module front_panel_tb;

	localparam int FRAMES     = 40;
	localparam int MAX_CYCLES = 16 + FRAMES * 20 + 100;

	logic       clock_1us;
	logic       arst_n;
	logic       enable;
	logic       digit_wr;
	logic [2:0] digit_idx;
	logic [3:0] digit_val;
	logic [3:0] kbd_rows = 4'b0000;
	logic [7:0] panel_bus;
	logic       in12_write_cathode;
	logic       in12_write_anode;
	logic       keyboard_write;
	logic       keyboard_read;
	logic       ms6205_write_addr_n;
	logic       ms6205_write_data_n;
	panel_pkg::panel_phase_e phase;

	// Reference model of the panel state.
	logic [3:0]  digit_model [`PANEL_TUBES];
	logic [2:0]  tube_pos;
	logic [1:0]  col_pos;
	logic [3:0]  cursor_model;
	logic [3:0]  key_model;
	logic        press_on;
	logic [3:0]  press_code;
	logic [3:0]  bus_col = 4'b0000;
	logic [31:0] lfsr;
	logic        started;
	int          cycles = 0;
	int          errors = 0;
	int          assert_errors;
	string       hex_chars = "0123456789ABCDEF";

	front_panel front_panel_inst (.*);

	bind front_panel front_panel_chk front_panel_chk_inst (
		.clock_1us           (clock_1us),
		.arst_n              (arst_n),
		.strobes             (strobes),
		.phase               (phase),
		.panel_bus           (panel_bus),
		.ms6205_write_addr_n (ms6205_write_addr_n),
		.ms6205_write_data_n (ms6205_write_data_n)
	);

	initial begin
		clock_1us = 1'b0;
		forever #50 clock_1us = ~clock_1us;
	end

	always @(posedge clock_1us) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the frames did not finish within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit. The newest bit lands at the bottom.
	task automatic rand_bits(input int n, output logic [7:0] v);
		v = 8'h00;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] want);
		assert (got === want) else begin
			errors++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
		end
	endtask

	// Key matrix. The column seen on the bus selects which row line is pulled.
	always @(posedge clock_1us) begin
		if (keyboard_write)
			bus_col = panel_bus[3:0];
		#1;
		if (press_on && bus_col[press_code[3:2]])
			kbd_rows = 4'b0001 << press_code[1:0];
		else
			kbd_rows = 4'b0000;
	end

	always @(posedge clock_1us) begin
		if (arst_n && !started) begin
			check_value("strobes", {4'h0, in12_write_cathode, in12_write_anode,
				keyboard_write, keyboard_read}, 8'h00);
			check_value("ms6205 pulses", {6'h00, ms6205_write_addr_n,
				ms6205_write_data_n}, 8'h03);
			check_value("panel_bus", panel_bus, 8'h00);
		end
		if (in12_write_cathode)
			check_value("panel_bus cathode", panel_bus, {4'h0, digit_model[tube_pos]});
		if (in12_write_anode)
			check_value("panel_bus anode", panel_bus, 8'(1 << tube_pos));
		if (keyboard_write)
			check_value("panel_bus column", panel_bus, 8'(1 << col_pos));
		if (!ms6205_write_addr_n)
			check_value("panel_bus cursor", panel_bus, {4'h0, cursor_model});
		if (!ms6205_write_data_n)
			check_value("panel_bus char", panel_bus, hex_chars[key_model]);
	end

	task automatic run_frame();
		logic [7:0] r;
		logic [2:0] mode;
		// The host changes one tube before the frame opens.
		rand_bits(3, r);
		digit_idx = 3'(r % `PANEL_TUBES);
		rand_bits(4, r);
		digit_val = 4'(r % 10);
		digit_wr = 1'b1;
		digit_model[digit_idx] = digit_val;
		@(posedge clock_1us);
		#1;
		digit_wr = 1'b0;
		// Mode 0 presses nothing and mode 1 any key.
		// Higher modes press a key in the column about to be scanned.
		rand_bits(3, r);
		mode = r[2:0];
		press_on = (mode != 3'd0);
		if (mode > 3'd1) begin
			rand_bits(2, r);
			press_code = {col_pos, r[1:0]};
		end else begin
			rand_bits(4, r);
			press_code = r[3:0];
		end
		enable = 1'b1;
		started = 1'b1;
		do @(posedge clock_1us); while (phase != panel_pkg::STOP);
		#1;
		enable = 1'b0;
		do @(posedge clock_1us); while (!keyboard_read);
		do @(posedge clock_1us); while (keyboard_read);
		#1;
		// Frame is over. Move the model on.
		if (press_on && (press_code[3:2] == col_pos)) begin
			key_model = press_code;
			cursor_model = cursor_model + 4'd1;
		end
		col_pos = col_pos + 2'd1;
		if (tube_pos == 3'(`PANEL_TUBES - 1))
			tube_pos = 3'd0;
		else
			tube_pos = tube_pos + 3'd1;
	endtask

	initial begin
		arst_n = 1'b0;
		enable = 1'b0;
		digit_wr = 1'b0;
		digit_idx = 3'd0;
		digit_val = 4'd0;
		press_on = 1'b0;
		press_code = 4'd0;
		tube_pos = 3'd0;
		col_pos = 2'd0;
		cursor_model = 4'd0;
		key_model = 4'd0;
		started = 1'b0;
		lfsr = 32'hba1dd1c5;
		for (int i = 0; i < `PANEL_TUBES; i++)
			digit_model[i] = 4'd0;
		repeat (16) @(posedge clock_1us);
		#1;
		arst_n = 1'b1;
		repeat (3) @(posedge clock_1us);
		#1;
		for (int f = 0; f < FRAMES; f++)
			run_frame();
		repeat (2) @(posedge clock_1us);
		assert_errors = front_panel_inst.front_panel_chk_inst.fail_count;
		$display("Checks done: %0d testbench errors, %0d assertion errors",
			errors, assert_errors);
		if (errors == 0 && assert_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/front_panel_chk.sv
`timescale 1ns/1ps
`default_nettype none

module front_panel_chk (
	input  logic                      clock_1us,
	input  logic                      arst_n,
	input  panel_pkg::panel_strobes_t strobes,
	input  panel_pkg::panel_phase_e   phase,
	input  logic [7:0]                panel_bus,
	input  logic                      ms6205_write_addr_n,
	input  logic                      ms6205_write_data_n
);

	int fail_count = 0;

	logic [5:0] lv;
	logic [4:0] ord;

	assign lv = strobes;
	// Write strobes in frame order, cathode first.
	assign ord = {strobes.lcd_data, strobes.lcd_addr, strobes.kbd_wr,
		strobes.anode_wr, strobes.cathode_wr};

	one_strobe: assert property (@(posedge clock_1us) disable iff (!arst_n)
		$onehot0(lv))
		else begin fail_count++; $error("More than one phase strobe is high."); end

	idle_bus: assert property (@(posedge clock_1us) disable iff (!arst_n)
		(lv == 6'b000000) |-> (panel_bus == 8'h00))
		else begin fail_count++; $error("Panel bus is not zero with no strobe."); end

	// Each MS6205 pulse comes with the rise of its strobe and nowhere else.
	addr_pulse: assert property (@(posedge clock_1us) disable iff (!arst_n)
		$rose(strobes.lcd_addr) == !ms6205_write_addr_n)
		else begin fail_count++; $error("MS6205 address pulse off its strobe rise."); end

	data_pulse: assert property (@(posedge clock_1us) disable iff (!arst_n)
		$rose(strobes.lcd_data) == !ms6205_write_data_n)
		else begin fail_count++; $error("MS6205 data pulse off its strobe rise."); end

	read_phase: assert property (@(posedge clock_1us) disable iff (!arst_n)
		$rose(strobes.kbd_rd) |-> (phase == panel_pkg::KEYBOARD_RD))
		else begin fail_count++; $error("Keyboard read strobe outside its phase."); end

	for (genvar i = 0; i < 6; i++) begin : g_width
		// Two cycles high, then low.
		width: assert property (@(posedge clock_1us) disable iff (!arst_n)
			$fell(lv[i]) |-> ($past(lv[i], 2) && !$past(lv[i], 3)))
			else begin fail_count++; $error("Strobe %0d not high for two cycles.", i); end
	end

	for (genvar i = 1; i < 5; i++) begin : g_order
		order: assert property (@(posedge clock_1us) disable iff (!arst_n)
			$rose(ord[i]) |-> $fell(ord[i - 1]))
			else begin fail_count++; $error("Write strobe %0d rose out of order.", i); end
	end

endmodule

`default_nettype wire

//--- logic/front_panel.sv
`timescale 1ns/1ps
`default_nettype none

module front_panel (
	input  logic                    clock_1us,
	input  logic                    arst_n,
	input  logic                    enable,
	input  logic                    digit_wr,
	input  logic [2:0]              digit_idx,
	input  logic [3:0]              digit_val,
	input  logic [3:0]              kbd_rows,
	output logic [7:0]              panel_bus,
	output logic                    in12_write_cathode,
	output logic                    in12_write_anode,
	output logic                    keyboard_write,
	output logic                    keyboard_read,
	output logic                    ms6205_write_addr_n,
	output logic                    ms6205_write_data_n,
	output panel_pkg::panel_phase_e phase
);

	panel_pkg::panel_strobes_t strobes;
	panel_pkg::nixie_out_t     nixie;
	panel_pkg::key_out_t       keys;

	panel_sequencer panel_sequencer_inst (
		.clock_1us           (clock_1us),
		.arst_n              (arst_n),
		.enable              (enable),
		.strobes             (strobes),
		.ms6205_write_addr_n (ms6205_write_addr_n),
		.ms6205_write_data_n (ms6205_write_data_n),
		.phase               (phase)
	);

	nixie_scan nixie_scan_inst (
		.clock_1us (clock_1us),
		.arst_n    (arst_n),
		.digit_wr  (digit_wr),
		.digit_idx (digit_idx),
		.digit_val (digit_val),
		.anode_wr  (strobes.anode_wr),
		.nixie     (nixie)
	);

	keypad_scan keypad_scan_inst (
		.clock_1us (clock_1us),
		.arst_n    (arst_n),
		.kbd_rd    (strobes.kbd_rd),
		.kbd_rows  (kbd_rows),
		.keys      (keys)
	);

	panel_bus_mux panel_bus_mux_inst (
		.strobes   (strobes),
		.nixie     (nixie),
		.keys      (keys),
		.panel_bus (panel_bus)
	);

	// Latch and keyboard lines are the phase strobes as they are.
	assign in12_write_cathode = strobes.cathode_wr;
	assign in12_write_anode   = strobes.anode_wr;
	assign keyboard_write     = strobes.kbd_wr;
	assign keyboard_read      = strobes.kbd_rd;

endmodule

`default_nettype wire

//--- logic/panel_bus_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "panel_defs.svh"

module panel_bus_mux (
	input  panel_pkg::panel_strobes_t strobes,
	input  panel_pkg::nixie_out_t     nixie,
	input  panel_pkg::key_out_t       keys,
	output logic [7:0]                panel_bus
);

	logic [7:0] key_ascii;

	// Hex digit to its ASCII character, '0'..'9' then 'A'..'F'.
	always_comb begin
		if (keys.key_code < 4'd10)
			key_ascii = 8'h30 + {4'h0, keys.key_code};
		else
			key_ascii = 8'h37 + {4'h0, keys.key_code};
	end

	// Only one strobe is up at a time, so the order here is arbitrary.
	// With no strobe the bus rests at zero.
	always_comb begin
		panel_bus = 8'h00;
		if (strobes.cathode_wr)
			panel_bus = {4'h0, nixie.cathode_code};
		else if (strobes.anode_wr)
			panel_bus = {{(8 - `PANEL_TUBES){1'b0}}, nixie.anode_sel};
		else if (strobes.kbd_wr)
			panel_bus = {{(8 - `PANEL_KEY_COLS){1'b0}}, keys.col_sel};
		else if (strobes.lcd_addr)
			panel_bus = {4'h0, keys.cursor};
		else if (strobes.lcd_data)
			panel_bus = key_ascii;
	end

endmodule

`default_nettype wire

//--- logic/keypad_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "panel_defs.svh"

module keypad_scan (
	input  logic                clock_1us,
	input  logic                arst_n,
	input  logic                kbd_rd,
	input  logic [3:0]          kbd_rows,
	output panel_pkg::key_out_t keys
);

	logic [1:0] col_idx;
	logic       kbd_rd_d;
	logic       last_rd;
	logic       row_any;
	logic [1:0] row_idx;
	logic [3:0] key_code;
	logic [3:0] cursor;
	logic       key_hit;

	// The read strobe lasts two cycles, rows are taken on the second.
	assign last_rd = kbd_rd && kbd_rd_d;

	// Lowest active row wins.
	always_comb begin
		row_any = |kbd_rows;
		casez (kbd_rows)
			4'b???1: row_idx = 2'd0;
			4'b??10: row_idx = 2'd1;
			4'b?100: row_idx = 2'd2;
			default: row_idx = 2'd3;
		endcase
	end

	always_ff @(negedge clock_1us or negedge arst_n) begin
		if (!arst_n) begin
			kbd_rd_d <= 1'b0;
			col_idx  <= 2'd0;
			key_code <= 4'd0;
			cursor   <= 4'd0;
			key_hit  <= 1'b0;
		end else begin
			kbd_rd_d <= kbd_rd;
			if (last_rd) begin
				key_hit <= row_any;
				if (col_idx == 2'(`PANEL_KEY_COLS - 1))
					col_idx <= 2'd0;
				else
					col_idx <= col_idx + 2'd1;
				// A miss leaves the last key on the display.
				if (row_any) begin
					key_code <= {col_idx, row_idx};
					if (cursor == 4'(`PANEL_LCD_CHARS - 1))
						cursor <= 4'd0;
					else
						cursor <= cursor + 4'd1;
				end
			end
		end
	end

	assign keys.col_sel  = 4'b0001 << col_idx;
	assign keys.key_code = key_code;
	assign keys.cursor   = cursor;
	assign keys.key_hit  = key_hit;

endmodule

`default_nettype wire

//--- logic/nixie_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "panel_defs.svh"

module nixie_scan (
	input  logic                  clock_1us,
	input  logic                  arst_n,
	input  logic                  digit_wr,
	input  logic [2:0]            digit_idx,
	input  logic [3:0]            digit_val,
	input  logic                  anode_wr,
	output panel_pkg::nixie_out_t nixie
);

	// One BCD digit per tube, tube 0 first.
	logic [3:0] digits [`PANEL_TUBES];

	logic [2:0] anode_idx;
	logic       anode_wr_d;

	// Host writes, indices past the last tube are dropped.
	always_ff @(negedge clock_1us or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `PANEL_TUBES; i++)
				digits[i] <= 4'd0;
		end else if (digit_wr && (digit_idx < 3'(`PANEL_TUBES))) begin
			digits[digit_idx] <= digit_val;
		end
	end

	// Move to the next tube once the anode latch has taken its byte.
	always_ff @(negedge clock_1us or negedge arst_n) begin
		if (!arst_n) begin
			anode_wr_d <= 1'b0;
			anode_idx  <= 3'd0;
		end else begin
			anode_wr_d <= anode_wr;
			if (anode_wr_d && !anode_wr) begin
				if (anode_idx == 3'(`PANEL_TUBES - 1))
					anode_idx <= 3'd0;
				else
					anode_idx <= anode_idx + 3'd1;
			end
		end
	end

	assign nixie.anode_sel    = 6'b000001 << anode_idx;
	assign nixie.cathode_code = digits[anode_idx];

endmodule

`default_nettype wire

//--- logic/panel_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module panel_sequencer (
	input  logic                      clock_1us,
	input  logic                      arst_n,
	input  logic                      enable,
	output panel_pkg::panel_strobes_t strobes,
	output logic                      ms6205_write_addr_n,
	output logic                      ms6205_write_data_n,
	output panel_pkg::panel_phase_e   phase
);

	panel_pkg::panel_phase_e state;
	panel_pkg::panel_phase_e next_state;

	// Previous levels of the two MS6205 strobes, bit 1 is address.
	logic [1:0] lcd_d;
	logic [1:0] lcd_rise;

	assign phase = state;

	// A write phase stays put until its own strobe has been seen high,
	// so each strobe is held for two cycles before the next one rises.
	always_comb begin
		next_state = state;
		case (state)
			panel_pkg::NONE: begin
				if (enable)
					next_state = panel_pkg::CATHODES;
			end
			panel_pkg::CATHODES: begin
				if (strobes.cathode_wr)
					next_state = panel_pkg::ANODES;
			end
			panel_pkg::ANODES: begin
				if (strobes.anode_wr)
					next_state = panel_pkg::KEYBOARD_WR;
			end
			panel_pkg::KEYBOARD_WR: begin
				if (strobes.kbd_wr)
					next_state = panel_pkg::MC_ADDR;
			end
			panel_pkg::MC_ADDR: begin
				if (strobes.lcd_addr)
					next_state = panel_pkg::MC_DATA;
			end
			panel_pkg::MC_DATA: begin
				if (strobes.lcd_data)
					next_state = panel_pkg::STOP;
			end
			panel_pkg::STOP: begin
				// Wait here until the host closes the frame.
				if (!enable)
					next_state = panel_pkg::KEYBOARD_RD;
			end
			panel_pkg::KEYBOARD_RD: begin
				if (strobes.kbd_rd)
					next_state = panel_pkg::NONE;
			end
			default: begin
				next_state = panel_pkg::NONE;
			end
		endcase
	end

	always_ff @(negedge clock_1us or negedge arst_n) begin
		if (!arst_n) begin
			state <= panel_pkg::NONE;
		end else begin
			state <= next_state;
		end
	end

	// Strobes are registered from the current phase.
	// Write strobes need enable held, the read strobe needs it released.
	always_ff @(negedge clock_1us or negedge arst_n) begin
		if (!arst_n) begin
			strobes <= '0;
		end else begin
			strobes.cathode_wr <= (state == panel_pkg::CATHODES) && enable;
			strobes.anode_wr   <= (state == panel_pkg::ANODES) && enable;
			strobes.kbd_wr     <= (state == panel_pkg::KEYBOARD_WR) && enable;
			strobes.kbd_rd     <= (state == panel_pkg::KEYBOARD_RD) && !enable;
			strobes.lcd_addr   <= (state == panel_pkg::MC_ADDR) && enable;
			strobes.lcd_data   <= (state == panel_pkg::MC_DATA) && enable;
		end
	end

	// Edge detector for the MS6205 write lines.
	always_ff @(negedge clock_1us or negedge arst_n) begin
		if (!arst_n) begin
			lcd_d <= 2'b00;
		end else begin
			lcd_d <= {strobes.lcd_addr, strobes.lcd_data};
		end
	end

	// The controller latches on a short low pulse, one cycle from the strobe rise.
	assign lcd_rise = {strobes.lcd_addr, strobes.lcd_data} & ~lcd_d;

	assign ms6205_write_addr_n = ~lcd_rise[1];
	assign ms6205_write_data_n = ~lcd_rise[0];

endmodule

`default_nettype wire

//--- logic/panel_pkg.sv
`default_nettype none

package panel_pkg;

	// Frame phases, numbered as the panel firmware expects on the state pins.
	typedef enum logic [2:0] {
		NONE        = 3'd0,
		CATHODES    = 3'd1,
		ANODES      = 3'd2,
		KEYBOARD_WR = 3'd3,
		MC_ADDR     = 3'd4,
		MC_DATA     = 3'd5,
		KEYBOARD_RD = 3'd6,
		STOP        = 3'd7
	} panel_phase_e;

	// Phase strobes, active-high levels, at most one set at a time.
	typedef struct packed {
		logic cathode_wr;
		logic anode_wr;
		logic kbd_wr;
		logic kbd_rd;
		logic lcd_addr;
		logic lcd_data;
	} panel_strobes_t;

	// Nixie side of the bus.
	typedef struct packed {
		logic [3:0] cathode_code;	// BCD digit for the lit tube
		logic [5:0] anode_sel;		// one-hot tube select
	} nixie_out_t;

	// Keypad side of the bus.
	typedef struct packed {
		logic [3:0] col_sel;
		logic [3:0] key_code;
		logic [3:0] cursor;
		logic       key_hit;
	} key_out_t;

endpackage

`default_nettype wire

//--- include/panel_defs.svh
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// Number of IN-12 tubes on the multiplexed anode latch.
`define PANEL_TUBES 6

// Columns of the 4x4 key matrix, one scanned per frame.
`define PANEL_KEY_COLS 4

// Character positions on the MS6205 line, the echo cursor wraps here.
`define PANEL_LCD_CHARS 16

`endif
